//--- rtl/amo_pkg.sv
package amo_pkg;

    // Bus geometry
    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 64;
    localparam int unsigned IdWidth   = 4;
    localparam int unsigned StrbWidth = DataWidth / 8;

    // Default processor word that the top level passes down as WORD_WIDTH
    localparam int unsigned WordWidth = 32;

    // Atomic code fields
    localparam logic [1:0] AtopStore     = 2'b01;
    localparam logic [1:0] AtopLoad      = 2'b10;
    localparam logic [5:0] AtopSwap      = 6'b110000;
    localparam logic       AtopLittleEnd = 1'b0;

    // Response codes
    localparam logic [1:0] RespOkay   = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

    // Lower eight values follow the 3-bit operation field of the atomic code
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        CLR  = 4'd1,
        EOR  = 4'd2,
        SET  = 4'd3,
        SMAX = 4'd4,
        SMIN = 4'd5,
        UMAX = 4'd6,
        UMIN = 4'd7,
        SWAP = 4'd8
    } amo_op_e;

    typedef enum logic [1:0] {
        AMO_INVALID = 2'd0,
        AMO_LOAD    = 2'd1,
        AMO_STORE   = 2'd2
    } amo_class_e;

    typedef struct packed {
        logic [5:0]           atop;
        logic [AddrWidth-1:0] addr;
        logic [2:0]           size;
        logic [7:0]           len;
        logic                 lock;
        logic [IdWidth-1:0]   id;
        logic [DataWidth-1:0] wdata;
        logic [StrbWidth-1:0] strb;
    } amo_req_t;

    typedef struct packed {
        logic [IdWidth-1:0]   id;
        logic [1:0]           resp;
        logic [WordWidth-1:0] rdata;
    } amo_rsp_t;

    typedef struct packed {
        logic                 we;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
        logic [StrbWidth-1:0] strb;
    } mem_req_t;

endpackage

//--- rtl/amo_decoder.sv
module amo_decoder #(
    parameter int unsigned WORD_WIDTH = amo_pkg::WordWidth
) (
    input  amo_pkg::amo_req_t   req_i,
    output amo_pkg::amo_class_e class_o,
    output amo_pkg::amo_op_e    op_o
);

    // Largest size code that still fits in one processor word
    localparam logic [2:0] MaxSize = 3'($clog2(WORD_WIDTH / 8));

    logic is_swap;
    logic little_end;

    assign is_swap    = (req_i.atop == amo_pkg::AtopSwap);
    assign little_end = (req_i.atop[3] == amo_pkg::AtopLittleEnd);

    always_comb begin
        class_o = amo_pkg::AMO_INVALID;
        if (is_swap) begin
            class_o = amo_pkg::AMO_LOAD;
        end else if (little_end && req_i.atop[5:4] == amo_pkg::AtopLoad) begin
            class_o = amo_pkg::AMO_LOAD;
        end else if (little_end && req_i.atop[5:4] == amo_pkg::AtopStore) begin
            class_o = amo_pkg::AMO_STORE;
        end

        // Bursts, exclusive accesses and oversized accesses are rejected
        if (req_i.len != 8'd0 || req_i.lock || req_i.size > MaxSize) begin
            class_o = amo_pkg::AMO_INVALID;
        end
    end

    always_comb begin
        if (is_swap) begin
            op_o = amo_pkg::SWAP;
        end else begin
            op_o = amo_pkg::amo_op_e'({1'b0, req_i.atop[2:0]});
        end
    end

endmodule

//--- rtl/amo_alu.sv
module amo_alu #(
    parameter int unsigned WORD_WIDTH = amo_pkg::WordWidth
) (
    input  amo_pkg::amo_op_e        op_i,
    input  logic [WORD_WIDTH-1:0]   operand_a_i,
    input  logic [WORD_WIDTH-1:0]   operand_b_i,
    output logic [WORD_WIDTH-1:0]   result_o
);

    logic signed_gt;
    logic unsigned_gt;

    // Operand a is the old memory word and b comes with the request
    assign signed_gt   = ($signed(operand_a_i) > $signed(operand_b_i));
    assign unsigned_gt = (operand_a_i > operand_b_i);

    always_comb begin
        unique case (op_i)
            amo_pkg::ADD: begin
                result_o = operand_a_i + operand_b_i;
            end
            amo_pkg::CLR: begin
                result_o = operand_a_i & ~operand_b_i;
            end
            amo_pkg::EOR: begin
                result_o = operand_a_i ^ operand_b_i;
            end
            amo_pkg::SET: begin
                result_o = operand_a_i | operand_b_i;
            end
            amo_pkg::SMAX: begin
                result_o = signed_gt ? operand_a_i : operand_b_i;
            end
            amo_pkg::SMIN: begin
                result_o = signed_gt ? operand_b_i : operand_a_i;
            end
            amo_pkg::UMAX: begin
                result_o = unsigned_gt ? operand_a_i : operand_b_i;
            end
            amo_pkg::UMIN: begin
                result_o = unsigned_gt ? operand_b_i : operand_a_i;
            end
            amo_pkg::SWAP: begin
                result_o = operand_b_i;
            end
            default: begin
                result_o = operand_b_i;
            end
        endcase
    end

endmodule

//--- rtl/amo_lane.sv
module amo_lane #(
    parameter int unsigned WORD_WIDTH = amo_pkg::WordWidth
) (
    input  logic [amo_pkg::AddrWidth-1:0] addr_i,
    input  logic [amo_pkg::StrbWidth-1:0] strb_i,
    input  logic [amo_pkg::DataWidth-1:0] rdata_i,
    input  logic [amo_pkg::DataWidth-1:0] wdata_i,
    input  logic [WORD_WIDTH-1:0]         result_i,
    output logic [WORD_WIDTH-1:0]         old_word_o,
    output logic [WORD_WIDTH-1:0]         operand_o,
    output logic [amo_pkg::DataWidth-1:0] wdata_o
);

    localparam int unsigned Ratio      = amo_pkg::DataWidth / WORD_WIDTH;
    localparam int unsigned WordOffset = $clog2(WORD_WIDTH / 8);
    localparam int unsigned BusOffset  = $clog2(amo_pkg::StrbWidth);

    logic [amo_pkg::DataWidth-1:0]    byte_mask;
    logic [Ratio-1:0][WORD_WIDTH-1:0] rd_lanes;
    logic [Ratio-1:0][WORD_WIDTH-1:0] wd_lanes;
    logic [Ratio-1:0][WORD_WIDTH-1:0] res_lanes;

    // One strobe bit covers a full byte
    always_comb begin
        for (int i = 0; i < amo_pkg::StrbWidth; i++) begin
            byte_mask[i*8 +: 8] = {8{strb_i[i]}};
        end
    end

    assign rd_lanes = rdata_i & byte_mask;
    assign wd_lanes = wdata_i & byte_mask;

    if (Ratio == 1) begin : g_single_lane
        assign old_word_o = rd_lanes[0];
        assign operand_o  = wd_lanes[0];
        assign res_lanes  = result_i;
    end else begin : g_multi_lane
        logic [BusOffset-WordOffset-1:0] lane_idx;

        // Address bits right above the word offset pick the lane
        assign lane_idx   = addr_i[BusOffset-1:WordOffset];
        assign old_word_o = rd_lanes[lane_idx];
        assign operand_o  = wd_lanes[lane_idx];

        always_comb begin
            res_lanes           = '0;
            res_lanes[lane_idx] = result_i;
        end
    end

    assign wdata_o = res_lanes;

endmodule

//--- rtl/amo_sequencer.sv
module amo_sequencer #(
    parameter int unsigned WORD_WIDTH = amo_pkg::WordWidth
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  amo_pkg::amo_req_t             req_i,
    input  amo_pkg::amo_class_e           class_i,
    input  amo_pkg::amo_op_e              op_i,
    output amo_pkg::amo_op_e              op_o,
    output amo_pkg::amo_req_t             held_req_o,
    input  logic [WORD_WIDTH-1:0]         old_word_i,
    input  logic [amo_pkg::DataWidth-1:0] new_wdata_i,
    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output amo_pkg::mem_req_t             mem_req_o,
    input  logic                          mem_rsp_valid_i,
    input  logic [amo_pkg::DataWidth-1:0] mem_rdata_i,
    output logic [amo_pkg::DataWidth-1:0] read_data_o,
    output logic                          rsp_valid_o,
    output amo_pkg::amo_rsp_t             rsp_o
);

    typedef enum logic [2:0] {
        IDLE, ERROR_RESP, READ_REQ, READ_WAIT, WRITE_REQ, WRITE_WAIT, RESP
    } state_e;

    state_e                        state_d, state_q;
    amo_pkg::amo_req_t             req_q;
    amo_pkg::amo_class_e           class_q;
    amo_pkg::amo_op_e              op_q;
    logic [amo_pkg::DataWidth-1:0] read_data_q;
    logic                          req_accept;

    assign req_ready_o = (state_q == IDLE);
    assign req_accept  = req_valid_i && req_ready_o;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (req_accept) begin
                    state_d = (class_i == amo_pkg::AMO_INVALID) ? ERROR_RESP : READ_REQ;
                end
            end
            READ_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = READ_WAIT;
                end
            end
            READ_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_d = WRITE_REQ;
                end
            end
            WRITE_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = WRITE_WAIT;
                end
            end
            WRITE_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_d = RESP;
                end
            end
            ERROR_RESP, RESP: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Captured request payload and read data
    always_ff @(posedge clk_i) begin
        if (req_accept) begin
            req_q   <= req_i;
            class_q <= class_i;
            op_q    <= op_i;
        end
        if (state_q == READ_WAIT && mem_rsp_valid_i) begin
            read_data_q <= mem_rdata_i;
        end
    end

    assign op_o        = op_q;
    assign held_req_o  = req_q;
    assign read_data_o = read_data_q;

    // Write data only appears on the write phase
    assign mem_req_valid_o = (state_q == READ_REQ) || (state_q == WRITE_REQ);
    assign mem_req_o.we    = (state_q == WRITE_REQ);
    assign mem_req_o.addr  = req_q.addr;
    assign mem_req_o.wdata = (state_q == WRITE_REQ) ? new_wdata_i : '0;
    assign mem_req_o.strb  = req_q.strb;

    assign rsp_valid_o = (state_q == RESP) || (state_q == ERROR_RESP);
    assign rsp_o.id    = req_q.id;

    always_comb begin
        if (state_q == ERROR_RESP) begin
            rsp_o.resp  = amo_pkg::RespSlvErr;
            rsp_o.rdata = '1;
        end else begin
            rsp_o.resp  = amo_pkg::RespOkay;
            // Stores return no data
            if (class_q == amo_pkg::AMO_STORE) begin
                rsp_o.rdata = '0;
            end else begin
                rsp_o.rdata = amo_pkg::WordWidth'(old_word_i);
            end
        end
    end

    a_mem_req_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
    );

    a_no_rsp_in_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        state_q == IDLE |-> !mem_rsp_valid_i
    );

endmodule

//--- rtl/amo_adapter.sv
module amo_adapter #(
    parameter int unsigned WORD_WIDTH = amo_pkg::WordWidth
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  amo_pkg::amo_req_t             req_i,
    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output amo_pkg::mem_req_t             mem_req_o,
    input  logic                          mem_rsp_valid_i,
    input  logic [amo_pkg::DataWidth-1:0] mem_rdata_i,
    output logic                          rsp_valid_o,
    output amo_pkg::amo_rsp_t             rsp_o
);

    amo_pkg::amo_class_e           dec_class;
    amo_pkg::amo_op_e              dec_op;
    amo_pkg::amo_op_e              held_op;
    amo_pkg::amo_req_t             held_req;
    logic [amo_pkg::DataWidth-1:0] read_data;
    logic [amo_pkg::DataWidth-1:0] new_wdata;
    logic [WORD_WIDTH-1:0]         old_word;
    logic [WORD_WIDTH-1:0]         operand;
    logic [WORD_WIDTH-1:0]         result;

    // Decoder judges the incoming request before acceptance
    amo_decoder #(
        .WORD_WIDTH ( WORD_WIDTH )
    ) i_decoder (
        .req_i   ( req_i     ),
        .class_o ( dec_class ),
        .op_o    ( dec_op    )
    );

    amo_sequencer #(
        .WORD_WIDTH ( WORD_WIDTH )
    ) i_sequencer (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .req_valid_i     ( req_valid_i     ),
        .req_ready_o     ( req_ready_o     ),
        .req_i           ( req_i           ),
        .class_i         ( dec_class       ),
        .op_i            ( dec_op          ),
        .op_o            ( held_op         ),
        .held_req_o      ( held_req        ),
        .old_word_i      ( old_word        ),
        .new_wdata_i     ( new_wdata       ),
        .mem_req_valid_o ( mem_req_valid_o ),
        .mem_req_ready_i ( mem_req_ready_i ),
        .mem_req_o       ( mem_req_o       ),
        .mem_rsp_valid_i ( mem_rsp_valid_i ),
        .mem_rdata_i     ( mem_rdata_i     ),
        .read_data_o     ( read_data       ),
        .rsp_valid_o     ( rsp_valid_o     ),
        .rsp_o           ( rsp_o           )
    );

    amo_lane #(
        .WORD_WIDTH ( WORD_WIDTH )
    ) i_lane (
        .addr_i     ( held_req.addr  ),
        .strb_i     ( held_req.strb  ),
        .rdata_i    ( read_data      ),
        .wdata_i    ( held_req.wdata ),
        .result_i   ( result         ),
        .old_word_o ( old_word       ),
        .operand_o  ( operand        ),
        .wdata_o    ( new_wdata      )
    );

    amo_alu #(
        .WORD_WIDTH ( WORD_WIDTH )
    ) i_alu (
        .op_i        ( held_op  ),
        .operand_a_i ( old_word ),
        .operand_b_i ( operand  ),
        .result_o    ( result   )
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock #(
    parameter int unsigned PERIOD = 8
) (
    output logic clk_o
);

    // Free running with the first rising edge after half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

//--- tests/amo_adapter_tb.sv
module amo_adapter_tb;

    localparam int unsigned WaitLimit = 300;
    localparam int unsigned RunLimit  = 30000;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          req_valid_i;
    logic                          req_ready_o;
    amo_pkg::amo_req_t             req_i;
    logic                          mem_req_valid_o;
    logic                          mem_req_ready_i;
    amo_pkg::mem_req_t             mem_req_o;
    logic                          mem_rsp_valid_i;
    logic [amo_pkg::DataWidth-1:0] mem_rdata_i;
    logic                          rsp_valid_o;
    amo_pkg::amo_rsp_t             rsp_o;

    integer      seed = 32'h485d9fcd;
    int unsigned ready_pct;
    int unsigned errors;
    int unsigned tests_run;
    int unsigned tests_failed;
    logic        timeout_seen = 1'b0;

    // Memory model storage and its reference copy with one bus word per entry
    logic [63:0]       mem    [256];
    logic [63:0]       shadow [256];
    amo_pkg::amo_rsp_t exp_rsp_q [$];
    amo_pkg::mem_req_t exp_mem_q [$];

    tb_clock #(
        .PERIOD ( 8 )
    ) i_clock (
        .clk_o ( clk_i )
    );

    amo_adapter #(
        .WORD_WIDTH ( amo_pkg::WordWidth )
    ) dut (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .req_valid_i     ( req_valid_i     ),
        .req_ready_o     ( req_ready_o     ),
        .req_i           ( req_i           ),
        .mem_req_valid_o ( mem_req_valid_o ),
        .mem_req_ready_i ( mem_req_ready_i ),
        .mem_req_o       ( mem_req_o       ),
        .mem_rsp_valid_i ( mem_rsp_valid_i ),
        .mem_rdata_i     ( mem_rdata_i     ),
        .rsp_valid_o     ( rsp_valid_o     ),
        .rsp_o           ( rsp_o           )
    );

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic logic [63:0] fill_pattern(input logic [7:0] idx);
        return {8{idx}} ^ 64'h9e3779b97f4a7c15;
    endfunction

    function automatic logic [63:0] strb_to_mask(input logic [7:0] strb);
        logic [63:0] mask;
        mask = '0;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                mask[b*8 +: 8] = 8'hff;
            end
        end
        return mask;
    endfunction

    // Expected response, write data and memory word for one request
    function automatic void amo_expect(
        input  amo_pkg::amo_req_t req,
        input  logic [63:0]       bus_old,
        output logic              valid,
        output amo_pkg::amo_rsp_t rsp,
        output logic [63:0]       wr_data,
        output logic [63:0]       bus_new
    );
        logic [63:0] mask;
        logic [31:0] old_w;
        logic [31:0] opnd;
        logic [31:0] new_w;
        logic        swap;
        logic        store;
        int          shift;
        int          so;
        int          sb;
        swap  = (req.atop == 6'b110000);
        store = (req.atop[5:4] == 2'b01);
        valid = swap || (req.atop[3] == 1'b0 &&
                         (req.atop[5:4] == 2'b01 || req.atop[5:4] == 2'b10));
        valid = valid && req.len == 8'd0 && !req.lock && req.size <= 3'd2;
        mask  = strb_to_mask(req.strb);
        shift = req.addr[2] ? 32 : 0;
        old_w = 32'((bus_old & mask) >> shift);
        opnd  = 32'((req.wdata & mask) >> shift);
        so    = old_w;
        sb    = opnd;
        case (req.atop[2:0])
            3'd0: new_w = old_w + opnd;
            3'd1: new_w = old_w & ~opnd;
            3'd2: new_w = old_w ^ opnd;
            3'd3: new_w = old_w | opnd;
            3'd4: new_w = (so > sb) ? old_w : opnd;
            3'd5: new_w = (so < sb) ? old_w : opnd;
            3'd6: new_w = (old_w > opnd) ? old_w : opnd;
            default: new_w = (old_w < opnd) ? old_w : opnd;
        endcase
        if (swap) begin
            new_w = opnd;
        end
        wr_data = {32'd0, new_w} << shift;
        bus_new = (bus_old & ~mask) | (wr_data & mask);
        rsp.id  = req.id;
        if (valid) begin
            rsp.resp  = 2'b00;
            rsp.rdata = store ? 32'd0 : old_w;
        end else begin
            rsp.resp  = 2'b10;
            rsp.rdata = '1;
            wr_data   = '0;
            bus_new   = bus_old;
        end
    endfunction

    function automatic amo_pkg::amo_req_t make_req(
        input logic [5:0] atop,
        input logic       lane,
        input logic [2:0] size,
        input logic [7:0] len,
        input logic       lock
    );
        amo_pkg::amo_req_t req;
        logic [31:0]       r;
        r         = rand32();
        req.atop  = atop;
        req.addr  = {21'd0, r[7:0], lane, 2'b00};
        req.size  = size;
        req.len   = len;
        req.lock  = lock;
        req.id    = r[11:8];
        req.wdata = {rand32(), rand32()};
        // Mostly full lane strobes and sometimes a partial word
        if (r[12]) begin
            req.strb = lane ? 8'hf0 : 8'h0f;
        end else begin
            req.strb = lane ? {r[16:13], 4'h0} : {4'h0, r[16:13]};
        end
        return req;
    endfunction

    // Records what the DUT must do and hands the request over
    task automatic issue(input amo_pkg::amo_req_t req);
        logic              valid;
        amo_pkg::amo_rsp_t rsp;
        amo_pkg::mem_req_t mr;
        logic [63:0]       wr;
        logic [63:0]       nw;
        logic [7:0]        idx;
        int unsigned       cycles;
        idx = req.addr[10:3];
        amo_expect(req, shadow[idx], valid, rsp, wr, nw);
        exp_rsp_q.push_back(rsp);
        if (valid) begin
            mr.we    = 1'b0;
            mr.addr  = req.addr;
            mr.wdata = '0;
            mr.strb  = req.strb;
            exp_mem_q.push_back(mr);
            mr.we    = 1'b1;
            mr.wdata = wr;
            exp_mem_q.push_back(mr);
            shadow[idx] = nw;
        end
        @(posedge clk_i);
        #1;
        req_i       = req;
        req_valid_i = 1'b1;
        cycles      = 0;
        @(negedge clk_i);
        while (!req_ready_o && cycles < WaitLimit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!req_ready_o) begin
            $display("timeout at %0t: request was never accepted", $time);
            timeout_seen = 1'b1;
        end
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int unsigned cycles;
        cycles = 0;
        while ((exp_rsp_q.size() != 0 || exp_mem_q.size() != 0) && cycles < WaitLimit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (exp_rsp_q.size() != 0 || exp_mem_q.size() != 0) begin
            $display("timeout at %0t: %s requests did not complete", $time, what);
            timeout_seen = 1'b1;
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < 256; i++) begin
            if (mem[i[7:0]] !== shadow[i[7:0]]) begin
                $display("FAILED at %0t: mem[%0d] expected %h, actual %h",
                         $time, i, shadow[i[7:0]], mem[i[7:0]]);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name, input int unsigned errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // Memory with random ready and one response 1 to 3 cycles after each transfer
    initial begin : memory_model
        amo_pkg::mem_req_t mreq;
        amo_pkg::mem_req_t held;
        amo_pkg::mem_req_t exp;
        logic [63:0]       rsp_data;
        logic [63:0]       mask;
        logic [7:0]        idx;
        logic              fire;
        logic              stalled;
        int unsigned       rsp_wait;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rdata_i     = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = fill_pattern(i[7:0]);
        end
        stalled  = 1'b0;
        held     = '0;
        rsp_data = '0;
        rsp_wait = 0;
        forever begin
            @(negedge clk_i);
            mreq = mem_req_o;
            fire = mem_req_valid_o && mem_req_ready_i;
            if (stalled && !mem_req_valid_o) begin
                $display("error at %0t: memory request withdrawn before transfer", $time);
                errors++;
            end else if (stalled && mreq !== held) begin
                $display("FAILED at %0t: mem_req_o expected %h, actual %h", $time, held, mreq);
                errors++;
            end
            stalled = mem_req_valid_o && !mem_req_ready_i;
            held    = mreq;
            @(posedge clk_i);
            #1;
            mem_rsp_valid_i = 1'b0;
            if (rsp_wait != 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    mem_rsp_valid_i = 1'b1;
                    mem_rdata_i     = rsp_data;
                end
            end
            if (fire) begin
                idx = mreq.addr[10:3];
                if (exp_mem_q.size() == 0) begin
                    $display("error at %0t: memory request with no atomic pending", $time);
                    errors++;
                end else begin
                    exp = exp_mem_q.pop_front();
                    if (mreq !== exp) begin
                        $display("FAILED at %0t: mem_req_o expected %h, actual %h",
                                 $time, exp, mreq);
                        errors++;
                    end
                end
                rsp_data = mem[idx];
                if (mreq.we) begin
                    mask     = strb_to_mask(mreq.strb);
                    mem[idx] = (mem[idx] & ~mask) | (mreq.wdata & mask);
                end
                rsp_wait = 32'd1 + rand32() % 32'd3;
            end
            mem_req_ready_i = (rand32() % 32'd100) < ready_pct;
        end
    end

    initial begin : rsp_checker
        amo_pkg::amo_rsp_t exp;
        forever begin
            @(negedge clk_i);
            if (rsp_valid_o && exp_rsp_q.size() == 0) begin
                $display("error at %0t: response with no request pending", $time);
                errors++;
            end else if (rsp_valid_o) begin
                exp = exp_rsp_q.pop_front();
                if (rsp_o.id !== exp.id) begin
                    $display("FAILED at %0t: rsp_o.id expected %h, actual %h",
                             $time, exp.id, rsp_o.id);
                    errors++;
                end
                if (rsp_o.resp !== exp.resp) begin
                    $display("FAILED at %0t: rsp_o.resp expected %b, actual %b",
                             $time, exp.resp, rsp_o.resp);
                    errors++;
                end
                if (rsp_o.rdata !== exp.rdata) begin
                    $display("FAILED at %0t: rsp_o.rdata expected %h, actual %h",
                             $time, exp.rdata, rsp_o.rdata);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (!timeout_seen && cycles < RunLimit) begin
            @(posedge clk_i);
            cycles++;
        end
        if (timeout_seen) begin
            $display("run stopped after a wait timed out");
        end else begin
            $display("run stopped at its overall cycle limit");
        end
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int unsigned       errs_before;
        logic [31:0]       r;
        rst_ni       = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        ready_pct    = 70;
        for (int i = 0; i < 256; i++) begin
            shadow[i[7:0]] = fill_pattern(i[7:0]);
        end
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        errs_before = errors;
        @(negedge clk_i);
        if (req_ready_o !== 1'b1) begin
            $display("FAILED at %0t: req_ready_o expected 1, actual %b", $time, req_ready_o);
            errors++;
        end
        if (mem_req_valid_o !== 1'b0) begin
            $display("FAILED at %0t: mem_req_valid_o expected 0, actual %b",
                     $time, mem_req_valid_o);
            errors++;
        end
        if (rsp_valid_o !== 1'b0) begin
            $display("FAILED at %0t: rsp_valid_o expected 0, actual %b", $time, rsp_valid_o);
            errors++;
        end
        end_test("test 1 reset state", errs_before);

        errs_before = errors;
        repeat (2) begin
            for (int op = 0; op < 8; op++) begin
                for (int lane = 0; lane < 2; lane++) begin
                    issue(make_req({3'b100, op[2:0]}, lane[0], 3'd2, 8'd0, 1'b0));
                    wait_drain("load");
                end
            end
            issue(make_req(6'b110000, 1'b0, 3'd2, 8'd0, 1'b0));
            wait_drain("swap");
            issue(make_req(6'b110000, 1'b1, 3'd1, 8'd0, 1'b0));
            wait_drain("swap");
        end
        end_test("test 2 atomic loads and swap", errs_before);

        errs_before = errors;
        for (int op = 0; op < 8; op++) begin
            for (int lane = 0; lane < 2; lane++) begin
                issue(make_req({3'b010, op[2:0]}, lane[0], 3'd2, 8'd0, 1'b0));
                wait_drain("store");
            end
        end
        check_memory();
        end_test("test 3 atomic stores", errs_before);

        errs_before = errors;
        issue(make_req(6'b000011, 1'b0, 3'd2, 8'd0, 1'b0));
        issue(make_req(6'b110101, 1'b1, 3'd2, 8'd0, 1'b0));
        issue(make_req(6'b101000, 1'b0, 3'd2, 8'd0, 1'b0));
        issue(make_req(6'b011010, 1'b1, 3'd2, 8'd0, 1'b0));
        issue(make_req(6'b100000, 1'b0, 3'd2, 8'd3, 1'b0));
        issue(make_req(6'b010001, 1'b1, 3'd2, 8'd0, 1'b1));
        issue(make_req(6'b100110, 1'b0, 3'd3, 8'd0, 1'b0));
        wait_drain("invalid");
        check_memory();
        end_test("test 4 invalid atomics", errs_before);

        // Mixed run issued back to back under heavy memory back-pressure
        errs_before = errors;
        ready_pct   = 35;
        repeat (40) begin
            r = rand32();
            case (r[2:0])
                3'd4: issue(make_req({3'b010, r[5:3]}, r[6], 3'd2, 8'd0, 1'b0));
                3'd5: issue(make_req(6'b110000, r[6], 3'd2, 8'd0, 1'b0));
                3'd6: issue(make_req({3'b100, r[5:3]}, r[6], 3'd3, 8'd0, r[7]));
                default: issue(make_req({3'b100, r[5:3]}, r[6], 3'd2, 8'd0, 1'b0));
            endcase
        end
        wait_drain("mixed");
        check_memory();
        end_test("test 5 back-pressure run", errs_before);

        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && !timeout_seen) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
rtl/amo_pkg.sv
rtl/amo_decoder.sv
rtl/amo_alu.sv
rtl/amo_lane.sv
rtl/amo_sequencer.sv
rtl/amo_adapter.sv
tests/tb_clock.sv
tests/amo_adapter_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= amo_adapter_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

check:
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
